//--- build.f
+incdir+.
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
dbg_cmd_decoder.sv
dbg_dump_serializer.sv
debug_unit_top.sv
tb_debug_unit.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_debug_unit -o tb_debug_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_debug_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

localparam int RX_TIMEOUT_CYCLES = 30 * CLKS_PER_BIT;  // Longest gap before a reply byte

// Host side 8N1 frame with one bit per CLKS_PER_BIT falling edges
task automatic send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int b = 0; b < 10; b++) begin
        uart_rx = frame[b];
        repeat (CLKS_PER_BIT) @(negedge clk);
    end
endtask

task automatic receive_byte(output byte_t data, output bit ok);
    int waited;
    data   = '0;
    ok     = 1'b0;
    waited = 0;
    while (uart_tx !== 1'b0 && waited < RX_TIMEOUT_CYCLES) begin
        @(negedge clk);
        waited++;
    end
    if (uart_tx !== 1'b0) return;  // Timed out
    repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of the start bit
    if (uart_tx !== 1'b0) return;
    for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[b] = uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    ok = (uart_tx === 1'b1);  // Stop bit
endtask

// Four bytes with the least significant first
task automatic receive_word(output word_t word, output bit ok);
    byte_t data;
    bit    byte_ok;
    word = '0;
    ok   = 1'b1;
    for (int i = 0; i < 4; i++) begin
        receive_byte(data, byte_ok);
        word[i*8 +: 8] = data;
        ok = ok && byte_ok;
    end
endtask

task automatic line_stays_idle(input int cycles, output bit quiet);
    quiet = 1'b1;
    for (int c = 0; c < cycles; c++) begin
        @(negedge clk);
        if (uart_tx !== 1'b1) quiet = 1'b0;
    end
endtask

`endif

//--- tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;
    import dbg_pkg::*;

    logic          clk;
    logic          reset;
    logic          uart_rx;
    logic          uart_tx;
    cpu_snapshot_t cpu_state;
    dmem_addr_t    mem_addr;
    word_t         mem_data;
    imem_write_t   imem_write;
    logic          cpu_enable;

    int         seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         enable_count;
    imem_addr_t written_addr[$];
    word_t      written_data[$];

    `include "tb_uart_tasks.svh"

    debug_unit_top i_dut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_uart_rx    (uart_rx),
        .o_uart_tx    (uart_tx),
        .i_cpu_state  (cpu_state),
        .o_mem_addr   (mem_addr),
        .i_mem_data   (mem_data),
        .o_imem_write (imem_write),
        .o_cpu_enable (cpu_enable)
    );

    assign mem_data = word_t'(mem_addr) * 32'h0101_0101 + 32'h0000_1000;  // Data memory model

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction memory log and enable counter
    always @(negedge clk) begin
        if (imem_write.we) begin
            written_addr.push_back(imem_write.addr);
            written_data.push_back(imem_write.data);
        end
        if (cpu_enable) enable_count++;
    end

    task automatic check_equal(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input string test_name, input bit ok, input string problem);
        assert (ok) else begin
            $display("%s: %s", test_name, problem);
            errors++;
        end
    endtask

    task automatic count_enable_high(input int cycles, output int highs);
        highs = 0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (cpu_enable) highs++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed", name);
        end
    endtask

    initial begin
        byte_t rx;
        bit    ok;
        word_t word;
        word_t load_words [3];
        int    highs;
        int    errs;
        seed         = 39;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        enable_count = 0;
        highs        = 0;
        reset        = 1'b1;
        uart_rx      = 1'b1;
        cpu_state    = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        errs = errors;
        check_equal("reset", "o_uart_tx", 1, uart_tx);
        check_equal("reset", "o_cpu_enable", 0, cpu_enable);
        check_equal("reset", "o_imem_write.we", 0, imem_write.we);
        check_equal("reset", "o_mem_addr", 0, mem_addr);
        finish_test("reset", errs);

        errs = errors;
        send_byte(CMD_MODE_CONT);
        receive_byte(rx, ok);
        check_true("mode_step", ok, "no reply to the continuous mode command");
        check_equal("mode_step", "continuous ack", 8'h52, rx);  // ASCII R
        count_enable_high(64, highs);
        check_equal("mode_step", "enable cycles in continuous mode", 64, highs);
        send_byte(CMD_MODE_STEP);
        receive_byte(rx, ok);
        check_true("mode_step", ok, "no reply to the step mode command");
        check_equal("mode_step", "step ack", 8'h52, rx);
        count_enable_high(64, highs);
        check_equal("mode_step", "enable cycles in step mode", 0, highs);
        enable_count = 0;
        send_byte(CMD_STEP);
        line_stays_idle(10 * CLKS_PER_BIT, ok);
        check_true("mode_step", ok, "a reply was sent after a step command");
        check_equal("mode_step", "enable cycles per step", 1, enable_count);
        finish_test("mode_step", errs);

        errs = errors;
        for (int i = 0; i < NUM_REGS; i++) begin
            cpu_state.reg_file[i*DATA_WIDTH +: DATA_WIDTH] = $random(seed);
        end
        send_byte(CMD_DUMP_REGS);
        for (int i = 0; i < 128; i++) begin
            receive_byte(rx, ok);
            check_true("reg_dump", ok, "a register dump byte was missing or badly framed");
            if (!ok) break;
            check_equal("reg_dump", $sformatf("byte %0d", i), cpu_state.reg_file[i*8 +: 8], rx);
        end
        line_stays_idle(2 * CLKS_PER_BIT, ok);
        check_true("reg_dump", ok, "more than 128 bytes came back");
        finish_test("reg_dump", errs);

        errs = errors;
        cpu_state.if_id = $random(seed);
        send_byte(CMD_DUMP_IF_ID);
        receive_word(word, ok);
        check_true("if_id_dump", ok, "the IF/ID reply was incomplete");
        check_equal("if_id_dump", "latch", cpu_state.if_id, word);
        finish_test("if_id_dump", errs);

        errs = errors;
        send_byte(CMD_READ_MEM);
        send_byte(8'h2A);
        receive_word(word, ok);
        check_true("mem_read", ok, "the memory reply was incomplete");
        check_equal("mem_read", "o_mem_addr", 32'h2A, mem_addr);
        check_equal("mem_read", "word", 32'h2A * 32'h0101_0101 + 32'h1000, word);
        finish_test("mem_read", errs);

        errs = errors;
        send_byte(CMD_MODE_CONT);  // Load must freeze a running processor
        receive_byte(rx, ok);
        check_true("prog_load", ok, "no reply to the continuous mode command");
        written_addr.delete();
        written_data.delete();
        send_byte(CMD_LOAD_PROG);
        send_byte(8'd3);
        enable_count = 0;
        for (int w = 0; w < 3; w++) begin
            load_words[w] = $random(seed);
            for (int b = 0; b < 4; b++) begin
                if (w == 2 && b == 3) highs = enable_count;  // Last byte releases the processor
                send_byte(load_words[w][b*8 +: 8]);
            end
        end
        check_equal("prog_load", "enable cycles during load", 0, highs);
        receive_byte(rx, ok);
        check_true("prog_load", ok, "no reply after the load");
        check_equal("prog_load", "load ack", 8'h52, rx);
        check_equal("prog_load", "write count", 3, written_addr.size());
        for (int w = 0; w < 3; w++) begin
            if (w < written_addr.size()) begin
                check_equal("prog_load", $sformatf("address %0d", w), w, written_addr[w]);
                check_equal("prog_load", $sformatf("word %0d", w), load_words[w],
                            written_data[w]);
            end
        end
        count_enable_high(64, highs);
        check_equal("prog_load", "enable cycles after load", 64, highs);
        finish_test("prog_load", errs);

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- debug_unit_top.sv
`timescale 1ns/1ps

module debug_unit_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_uart_rx,
    output logic                   o_uart_tx,
    input  dbg_pkg::cpu_snapshot_t i_cpu_state,
    output dbg_pkg::dmem_addr_t    o_mem_addr,
    input  dbg_pkg::word_t         i_mem_data,
    output dbg_pkg::imem_write_t   o_imem_write,
    output logic                   o_cpu_enable
);
    import dbg_pkg::*;

    byte_t     rx_byte;
    logic      rx_valid;
    logic      dump_valid;
    dump_src_e dump_src;
    logic      dump_ready;
    byte_t     tx_byte;
    logic      tx_valid;
    logic      tx_ready;

    uart_rx u_uart_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rx    (i_uart_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    dbg_cmd_decoder u_cmd_decoder (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_byte    (rx_byte),
        .i_rx_valid   (rx_valid),
        .o_dump_valid (dump_valid),
        .o_dump_src   (dump_src),
        .i_dump_ready (dump_ready),
        .o_mem_addr   (o_mem_addr),
        .o_imem_write (o_imem_write),
        .o_cpu_enable (o_cpu_enable)
    );

    dbg_dump_serializer u_dump_serializer (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_valid (dump_valid),
        .i_dump_src   (dump_src),
        .o_dump_ready (dump_ready),
        .i_cpu_state  (i_cpu_state),
        .i_mem_data   (i_mem_data),
        .o_tx_byte    (tx_byte),
        .o_tx_valid   (tx_valid),
        .i_tx_ready   (tx_ready)
    );

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_byte  (tx_byte),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .o_tx    (o_uart_tx)
    );

endmodule

//--- dbg_dump_serializer.sv
`timescale 1ns/1ps

module dbg_dump_serializer (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_dump_valid,
    input  dbg_pkg::dump_src_e     i_dump_src,
    output logic                   o_dump_ready,
    input  dbg_pkg::cpu_snapshot_t i_cpu_state,
    input  dbg_pkg::word_t         i_mem_data,
    output dbg_pkg::byte_t         o_tx_byte,
    output logic                   o_tx_valid,
    input  logic                   i_tx_ready
);
    import dbg_pkg::*;

    reg_file_t  reply;
    logic [7:0] bytes_left;
    logic       dump_xfer;
    logic       tx_xfer;

    assign o_dump_ready = (bytes_left == '0) && i_tx_ready;
    assign o_tx_valid   = (bytes_left != '0);
    assign o_tx_byte    = reply[7:0];
    assign dump_xfer    = i_dump_valid && o_dump_ready;
    assign tx_xfer      = o_tx_valid && i_tx_ready;

    // Snapshot register shifted down one byte per sent byte
    always_ff @(posedge i_clk) begin
        if (dump_xfer) begin
            case (i_dump_src)
                DUMP_REGS:  reply <= i_cpu_state.reg_file;
                DUMP_IF_ID: reply <= reg_file_t'(i_cpu_state.if_id);
                DUMP_MEM:   reply <= reg_file_t'(i_mem_data);
                default:    reply <= reg_file_t'(ACK_BYTE);
            endcase
        end else if (tx_xfer) begin
            reply <= reply >> 8;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            bytes_left <= '0;
        end else if (dump_xfer) begin
            case (i_dump_src)
                DUMP_REGS:  bytes_left <= 8'(REG_DUMP_BYTES);
                DUMP_IF_ID: bytes_left <= 8'(IF_ID_WIDTH / 8);
                DUMP_MEM:   bytes_left <= 8'(DATA_WIDTH / 8);
                default:    bytes_left <= 8'd1;
            endcase
        end else if (tx_xfer) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

endmodule

//--- dbg_cmd_decoder.sv
`timescale 1ns/1ps

module dbg_cmd_decoder (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  dbg_pkg::byte_t       i_rx_byte,
    input  logic                 i_rx_valid,
    output logic                 o_dump_valid,
    output dbg_pkg::dump_src_e   o_dump_src,
    input  logic                 i_dump_ready,
    output dbg_pkg::dmem_addr_t  o_mem_addr,
    output dbg_pkg::imem_write_t o_imem_write,
    output logic                 o_cpu_enable
);
    import dbg_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GET_ADDR,
        GET_COUNT,
        GET_WORD,
        REQUEST
    } state_e;

    state_e     state;
    logic       cont_mode;
    logic       step_pulse;
    logic       loading;
    byte_t      words_left;
    logic [1:0] byte_idx;
    imem_addr_t wr_addr;
    logic       we_q;
    word_t      word_buf;

    assign o_dump_valid = (state == REQUEST);
    assign o_imem_write = '{we: we_q, addr: wr_addr, data: word_buf};
    assign o_cpu_enable = (cont_mode || step_pulse) && !loading;

    always_ff @(posedge i_clk) begin
        if (state == GET_WORD && i_rx_valid) begin
            word_buf <= {i_rx_byte, word_buf[DATA_WIDTH-1:8]};  // Little endian assembly
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= IDLE;
            o_dump_src <= DUMP_ACK;
            cont_mode  <= 1'b0;
            step_pulse <= 1'b0;
            loading    <= 1'b0;
            words_left <= '0;
            byte_idx   <= '0;
            wr_addr    <= '0;
            we_q       <= 1'b0;
            o_mem_addr <= '0;
        end else begin
            step_pulse <= 1'b0;
            we_q       <= 1'b0;
            if (we_q) wr_addr <= wr_addr + 1'b1;  // Next word goes one address up
            case (state)
                IDLE: begin
                    // Bytes during a reply are dropped
                    if (i_rx_valid && i_dump_ready) begin
                        case (i_rx_byte)
                            CMD_DUMP_REGS: begin
                                o_dump_src <= DUMP_REGS;
                                state      <= REQUEST;
                            end
                            CMD_DUMP_IF_ID: begin
                                o_dump_src <= DUMP_IF_ID;
                                state      <= REQUEST;
                            end
                            CMD_READ_MEM:  state <= GET_ADDR;
                            CMD_LOAD_PROG: state <= GET_COUNT;
                            CMD_MODE_CONT: begin
                                cont_mode  <= 1'b1;
                                o_dump_src <= DUMP_ACK;
                                state      <= REQUEST;
                            end
                            CMD_MODE_STEP: begin
                                cont_mode  <= 1'b0;
                                o_dump_src <= DUMP_ACK;
                                state      <= REQUEST;
                            end
                            CMD_STEP:      step_pulse <= !cont_mode;
                            default:       state <= IDLE;
                        endcase
                    end
                end
                GET_ADDR: begin
                    if (i_rx_valid) begin
                        o_mem_addr <= i_rx_byte[DMEM_ADDR_WIDTH-1:0];
                        o_dump_src <= DUMP_MEM;
                        state      <= REQUEST;
                    end
                end
                GET_COUNT: begin
                    if (i_rx_valid) begin
                        words_left <= i_rx_byte;
                        byte_idx   <= '0;
                        wr_addr    <= '0;
                        if (i_rx_byte == 8'd0) begin
                            o_dump_src <= DUMP_ACK;
                            state      <= REQUEST;
                        end else begin
                            loading <= 1'b1;  // Processor frozen while memory is rewritten
                            state   <= GET_WORD;
                        end
                    end
                end
                GET_WORD: begin
                    if (i_rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            we_q       <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 8'd1) begin
                                loading    <= 1'b0;
                                o_dump_src <= DUMP_ACK;
                                state      <= REQUEST;
                            end
                        end
                    end
                end
                REQUEST: begin
                    if (i_dump_ready) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic           i_clk,
    input  logic           i_reset,
    input  dbg_pkg::byte_t i_byte,
    input  logic           i_valid,
    output logic           o_ready,
    output logic           o_tx
);
    import dbg_pkg::*;

    logic [9:0] frame;
    logic [3:0] bit_cnt;
    baud_cnt_t  clk_cnt;
    logic       busy;

    assign o_ready = !busy;
    assign o_tx    = frame[0];  // Frame refills with ones, so idle line stays high

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            frame   <= '1;
            bit_cnt <= '0;
            clk_cnt <= '0;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (i_valid) begin
                frame   <= {1'b1, i_byte, 1'b0};  // Stop, data, start
                bit_cnt <= '0;
                clk_cnt <= '0;
                busy    <= 1'b1;
            end
        end else if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) busy <= 1'b0;  // Stop bit fully sent
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_rx,
    output dbg_pkg::byte_t o_byte,
    output logic           o_valid
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e state;
    logic      rx_meta;
    logic      rx_sync;
    baud_cnt_t clk_cnt;
    logic [2:0] bit_idx;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_byte  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: begin
                    // Half bit less the synchronizer and detect delay
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 3)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // High again means a glitch
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        o_byte  <= {rx_sync, o_byte[7:1]};  // LSB arrives first
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        o_valid <= rx_sync;  // Framing error drops the byte
                        state   <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- dbg_pkg.sv
package dbg_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int NUM_REGS        = 32;
    localparam int REG_DUMP_BYTES  = DATA_WIDTH * NUM_REGS / 8;
    localparam int IF_ID_WIDTH     = 32;
    localparam int IMEM_ADDR_WIDTH = 6;
    localparam int DMEM_ADDR_WIDTH = 6;
    localparam int CLKS_PER_BIT    = 16;  // Small divider so simulation stays short

    typedef logic [DATA_WIDTH-1:0]            word_t;
    typedef logic [DATA_WIDTH*NUM_REGS-1:0]   reg_file_t;
    typedef logic [IF_ID_WIDTH-1:0]           if_id_t;
    typedef logic [IMEM_ADDR_WIDTH-1:0]       imem_addr_t;
    typedef logic [DMEM_ADDR_WIDTH-1:0]       dmem_addr_t;
    typedef logic [7:0]                       byte_t;
    typedef logic [$clog2(CLKS_PER_BIT)-1:0]  baud_cnt_t;

    // Host command codes
    localparam byte_t CMD_DUMP_REGS  = 8'h01;
    localparam byte_t CMD_DUMP_IF_ID = 8'h02;
    localparam byte_t CMD_LOAD_PROG  = 8'h07;
    localparam byte_t CMD_MODE_CONT  = 8'h08;
    localparam byte_t CMD_MODE_STEP  = 8'h09;
    localparam byte_t CMD_STEP       = 8'h0A;
    localparam byte_t CMD_READ_MEM   = 8'h0B;

    localparam byte_t ACK_BYTE       = 8'h52;  // ASCII R

    typedef enum logic [1:0] {
        DUMP_REGS,
        DUMP_IF_ID,
        DUMP_MEM,
        DUMP_ACK
    } dump_src_e;

    // Processor state seen by the debugger
    typedef struct packed {
        reg_file_t reg_file;
        if_id_t    if_id;
    } cpu_snapshot_t;

    typedef struct packed {
        logic       we;
        imem_addr_t addr;
        word_t      data;
    } imem_write_t;

endpackage
